/* source/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath sizes
`define WORD_WIDTH    32
`define REG_COUNT     32
`define REG_IDX_WIDTH 5
`define ZERO_REG      5'd31            // XZR

`define START_PC      32'h0000_1000    // first fetch after reset

// R format opcodes in inst[31:21]
`define OP_ADD        11'b100_0101_1000
`define OP_SUB        11'b110_0101_1000
`define OP_AND        11'b100_0101_0000
`define OP_ORR        11'b101_0101_0000
`define OP_EOR        11'b110_0101_0000

// I format opcodes in inst[31:22]
`define OP_ADDI       10'b10_0100_0100
`define OP_SUBI       10'b11_0100_0100

// D format, CB format in inst[31:24], B format in inst[31:26]
`define OP_LDUR       11'b111_1100_0010
`define OP_STUR       11'b111_1100_0000
`define OP_CBZ        8'b1011_0100
`define OP_B          6'b00_0101

`endif

/* source/cpuPkg.sv */
`include "cpu_settings.svh"

package cpuPkg;

    typedef logic [`WORD_WIDTH-1:0]    wordT;
    typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS     // first operand straight through, for cbz
    } aluOpT;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrc;       // immediate as second operand
        logic  branch;       // conditional, taken on zero
        logic  uncondBranch;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT   ctrl;
        regIdxT readIdx1;
        regIdxT readIdx2;
        regIdxT writeIdx;
        wordT   imm;         // already extended and scaled
    } decodeT;

    typedef struct packed {
        wordT addr;
        wordT storeData;
        logic read;
        logic write;
    } memReqT;

    typedef struct packed {
        logic   en;
        regIdxT idx;
        wordT   data;
    } regWriteT;

endpackage

/* source/programCounter.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module programCounter (
    input  logic         clk,
    input  logic         rstN,
    input  cpuPkg::wordT imm,
    input  logic         branch,
    input  logic         uncondBranch,
    input  logic         zero,
    output cpuPkg::wordT pc
);

    cpuPkg::wordT seqPc;
    cpuPkg::wordT targetPc;
    logic         takeBranch;

    assign seqPc    = pc + cpuPkg::wordT'(4);
    assign targetPc = pc + imm;     // imm comes pre-scaled from the decoder

    // b always jumps, cbz only when the register was zero
    assign takeBranch = uncondBranch | (branch & zero);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `START_PC;
        end else if (takeBranch) begin
            pc <= targetPc;
        end else begin
            pc <= seqPc;
        end
    end

endmodule

/* source/instructionDecoder.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module instructionDecoder (
    input  cpuPkg::wordT   inst,
    output cpuPkg::decodeT dec
);

    cpuPkg::regIdxT rn;
    cpuPkg::regIdxT rm;
    cpuPkg::regIdxT rd;
    logic [10:0]    opLong;     // R and D formats
    logic [9:0]     opImm;      // I format
    logic [7:0]     opCb;
    logic [5:0]     opB;
    logic           isRType;

    assign rn     = inst[9:5];
    assign rm     = inst[20:16];
    assign rd     = inst[4:0];      // also Rt
    assign opLong = inst[31:21];
    assign opImm  = inst[31:22];
    assign opCb   = inst[31:24];
    assign opB    = inst[31:26];

    assign isRType = (opLong == `OP_ADD) || (opLong == `OP_SUB) || (opLong == `OP_AND)
                  || (opLong == `OP_ORR) || (opLong == `OP_EOR);

    always_comb begin
        dec = '0;   // unknown opcode leaves every control low
        if (isRType) begin
            dec.ctrl.regWrite = 1'b1;
            dec.readIdx1      = rn;
            dec.readIdx2      = rm;
            dec.writeIdx      = rd;
            case (opLong)
                `OP_SUB: dec.ctrl.aluOp = cpuPkg::ALU_SUB;
                `OP_AND: dec.ctrl.aluOp = cpuPkg::ALU_AND;
                `OP_ORR: dec.ctrl.aluOp = cpuPkg::ALU_OR;
                `OP_EOR: dec.ctrl.aluOp = cpuPkg::ALU_XOR;
                default: dec.ctrl.aluOp = cpuPkg::ALU_ADD;
            endcase
        end else if ((opImm == `OP_ADDI) || (opImm == `OP_SUBI)) begin
            dec.ctrl.regWrite = 1'b1;
            dec.ctrl.aluSrc   = 1'b1;
            dec.ctrl.aluOp    = (opImm == `OP_SUBI) ? cpuPkg::ALU_SUB : cpuPkg::ALU_ADD;
            dec.readIdx1      = rn;
            dec.writeIdx      = rd;
            dec.imm           = cpuPkg::wordT'(inst[21:10]);  // zero extended imm12
        end else if (opLong == `OP_LDUR) begin
            dec.ctrl.regWrite = 1'b1;
            dec.ctrl.memRead  = 1'b1;
            dec.ctrl.memToReg = 1'b1;
            dec.ctrl.aluSrc   = 1'b1;
            dec.ctrl.aluOp    = cpuPkg::ALU_ADD;
            dec.readIdx1      = rn;
            dec.writeIdx      = rd;
            dec.imm           = cpuPkg::wordT'(signed'(inst[20:12]));
        end else if (opLong == `OP_STUR) begin
            dec.ctrl.memWrite = 1'b1;
            dec.ctrl.aluSrc   = 1'b1;
            dec.ctrl.aluOp    = cpuPkg::ALU_ADD;
            dec.readIdx1      = rn;
            dec.readIdx2      = rd;     // Rt supplies the store data
            dec.imm           = cpuPkg::wordT'(signed'(inst[20:12]));
        end else if (opCb == `OP_CBZ) begin
            // Rt is tested through the first operand
            dec.ctrl.branch = 1'b1;
            dec.ctrl.aluOp  = cpuPkg::ALU_PASS;
            dec.readIdx1    = rd;
            dec.imm         = cpuPkg::wordT'(signed'({inst[23:5], 2'b00}));
        end else if (opB == `OP_B) begin
            dec.ctrl.uncondBranch = 1'b1;
            dec.imm               = cpuPkg::wordT'(signed'({inst[25:0], 2'b00}));
        end
    end

endmodule

/* source/registerFile.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module registerFile (
    input  logic             clk,
    input  logic             rstN,
    input  cpuPkg::regIdxT   readIdx1,
    input  cpuPkg::regIdxT   readIdx2,
    input  cpuPkg::regWriteT wr,
    output cpuPkg::wordT     rdData1,
    output cpuPkg::wordT     rdData2
);

    cpuPkg::wordT regs [`REG_COUNT];

    // register n comes out of reset holding n
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= cpuPkg::wordT'(i);
            end
        end else if (wr.en && (wr.idx != `ZERO_REG)) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // async reads, XZR always zero
    assign rdData1 = (readIdx1 == `ZERO_REG) ? '0 : regs[readIdx1];
    assign rdData2 = (readIdx2 == `ZERO_REG) ? '0 : regs[readIdx2];

endmodule

/* source/executeUnit.sv */
`timescale 1ns/10ps

module executeUnit (
    input  logic             rstN,
    input  cpuPkg::decodeT   dec,
    input  cpuPkg::wordT     rdData1,
    input  cpuPkg::wordT     rdData2,
    input  cpuPkg::wordT     loadData,
    output cpuPkg::memReqT   memReq,
    output cpuPkg::regWriteT regWb,
    output logic             zero
);

    cpuPkg::wordT opB;
    cpuPkg::wordT aluResult;

    assign opB = dec.ctrl.aluSrc ? dec.imm : rdData2;

    always_comb begin
        case (dec.ctrl.aluOp)
            cpuPkg::ALU_SUB:  aluResult = rdData1 - opB;
            cpuPkg::ALU_AND:  aluResult = rdData1 & opB;
            cpuPkg::ALU_OR:   aluResult = rdData1 | opB;
            cpuPkg::ALU_XOR:  aluResult = rdData1 ^ opB;
            cpuPkg::ALU_PASS: aluResult = rdData1;
            default:          aluResult = rdData1 + opB;    // add, address calc
        endcase
    end

    assign zero = (aluResult == '0);

    // data memory request, address from the alu
    assign memReq.addr      = aluResult;
    assign memReq.storeData = rdData2;
    assign memReq.read      = dec.ctrl.memRead;
    assign memReq.write     = dec.ctrl.memWrite & rstN;   // no stores in reset

    assign regWb.en   = dec.ctrl.regWrite & rstN;
    assign regWb.idx  = dec.writeIdx;
    assign regWb.data = dec.ctrl.memToReg ? loadData : aluResult;

endmodule

/* source/cpuTop.sv */
`timescale 1ns/10ps

module cpuTop (
    input  logic             clk,
    input  logic             rstN,
    output cpuPkg::wordT     instAddr,
    input  cpuPkg::wordT     inst,
    output cpuPkg::memReqT   memReq,
    input  cpuPkg::wordT     loadData,
    output cpuPkg::regWriteT regWb
);

    cpuPkg::decodeT dec;
    cpuPkg::wordT   rdData1;
    cpuPkg::wordT   rdData2;
    logic           zero;

    programCounter uPc (
        .clk          (clk),
        .rstN         (rstN),
        .imm          (dec.imm),
        .branch       (dec.ctrl.branch),
        .uncondBranch (dec.ctrl.uncondBranch),
        .zero         (zero),
        .pc           (instAddr)
    );

    instructionDecoder uDecoder (
        .inst (inst),
        .dec  (dec)
    );

    // write port fed straight back from the execute stage
    registerFile uRegs (
        .clk      (clk),
        .rstN     (rstN),
        .readIdx1 (dec.readIdx1),
        .readIdx2 (dec.readIdx2),
        .wr       (regWb),
        .rdData1  (rdData1),
        .rdData2  (rdData2)
    );

    executeUnit uExec (
        .rstN     (rstN),
        .dec      (dec),
        .rdData1  (rdData1),
        .rdData2  (rdData2),
        .loadData (loadData),
        .memReq   (memReq),
        .regWb    (regWb),
        .zero     (zero)
    );

endmodule

/* tests/cpu_assertions.sv */
`timescale 1ns/10ps

module cpuAssertions (
    input logic             clk,
    input logic             rstN,
    input cpuPkg::wordT     instAddr,
    input cpuPkg::memReqT   memReq,
    input cpuPkg::regWriteT regWb
);

    int assertFails = 0;    // read by the testbench at the end

    // one data access per cycle, load or store
    noReadAndWrite: assert property (@(posedge clk) !(memReq.read && memReq.write))
        else begin
            assertFails++;
            $error("memory read and write strobes set in the same cycle");
        end

    // pc is only defined once reset has loaded it
    alignedFetch: assert property (@(posedge clk) disable iff (!rstN)
                                   instAddr[1:0] == 2'b00)
        else begin
            assertFails++;
            $error("instruction address %h is not word aligned", instAddr);
        end

    // nothing may reach the register file while reset is held
    quietInReset: assert property (@(posedge clk) !rstN |-> !regWb.en)
        else begin
            assertFails++;
            $error("register write enabled during reset");
        end

endmodule

/* tests/cpuTb.sv */
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuTb;

    localparam int NUM_STEPS    = 185;    // random part, fixed loop, then parked on B
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_LIMIT  = 2 * NUM_STEPS + RESET_CYCLES;
    localparam int IMEM_WORDS   = 256;

    // one architectural step as the model sees it
    typedef struct packed {
        cpuPkg::wordT   nextPc;
        logic           wbEn;
        cpuPkg::regIdxT wbIdx;
        cpuPkg::wordT   wbData;
        logic           memRd;
        logic           memWr;
        cpuPkg::wordT   memAddr;
        cpuPkg::wordT   memData;
    } stepT;

    logic             clk;
    logic             rstN;
    cpuPkg::wordT     instAddr;
    cpuPkg::wordT     inst;
    cpuPkg::memReqT   memReq;
    cpuPkg::wordT     loadData;
    cpuPkg::regWriteT regWb;

    cpuPkg::wordT imem [IMEM_WORDS];
    cpuPkg::wordT dmem [8];
    cpuPkg::wordT refRegs [`REG_COUNT];   // model copies
    cpuPkg::wordT refMem [8];
    cpuPkg::wordT refPc;
    logic [31:0]  rngState;
    int           errorCount;
    int           checkCount;
    int           cycleCount;

    cpuTop dut (
        .clk      (clk),
        .rstN     (rstN),
        .instAddr (instAddr),
        .inst     (inst),
        .memReq   (memReq),
        .loadData (loadData),
        .regWb    (regWb)
    );

    bind cpuTop cpuAssertions uAsserts (
        .clk      (clk),
        .rstN     (rstN),
        .instAddr (instAddr),
        .memReq   (memReq),
        .regWb    (regWb)
    );

    always #10 clk = ~clk;

    // data memory, 8 words wrapping on addr[4:2]
    assign loadData = dmem[memReq.addr[4:2]];

    always @(posedge clk) begin
        if (memReq.write) begin
            dmem[memReq.addr[4:2]] <= memReq.storeData;
        end
    end

    always @(posedge clk) begin
        #1;
        inst = fetchWord(instAddr);
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the program did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pickReg(input logic [7:0] r);
        return (r[2:0] == 3'd0) ? 31 : int'(r % 31);    // xzr about one time in eight
    endfunction

    function automatic cpuPkg::wordT fetchWord(input cpuPkg::wordT addr);
        cpuPkg::wordT offset;
        offset = addr - `START_PC;
        return imem[offset[9:2]];
    endfunction

    function automatic cpuPkg::wordT encR(input logic [10:0] op, input int rm, input int rn,
                                          input int rd);
        return {op, rm[4:0], 6'd0, rn[4:0], rd[4:0]};
    endfunction

    function automatic cpuPkg::wordT encI(input logic [9:0] op, input int imm, input int rn,
                                          input int rd);
        return {op, imm[11:0], rn[4:0], rd[4:0]};
    endfunction

    function automatic cpuPkg::wordT encD(input logic [10:0] op, input int off, input int rn,
                                          input int rt);
        return {op, off[8:0], 2'b00, rn[4:0], rt[4:0]};
    endfunction

    function automatic cpuPkg::wordT encCbz(input int off, input int rt);
        return {`OP_CBZ, off[18:0], rt[4:0]};
    endfunction

    function automatic cpuPkg::wordT encB(input int off);
        return {`OP_B, off[25:0]};
    endfunction

    function automatic cpuPkg::wordT regValue(input cpuPkg::regIdxT idx);
        return (idx == `ZERO_REG) ? '0 : refRegs[idx];
    endfunction

    // expected outcome of one instruction from the architectural rules
    function automatic stepT modelStep(input cpuPkg::wordT pc, input cpuPkg::wordT ins);
        stepT         s;
        cpuPkg::wordT rn;
        cpuPkg::wordT rm;
        cpuPkg::wordT rt;
        cpuPkg::wordT addr;
        s        = '0;
        s.nextPc = pc + 32'd4;
        s.wbIdx  = ins[4:0];
        rn       = regValue(ins[9:5]);
        rm       = regValue(ins[20:16]);
        rt       = regValue(ins[4:0]);
        addr     = rn + {{23{ins[20]}}, ins[20:12]};
        case (ins[31:21])
            `OP_ADD:  s.wbData = rn + rm;
            `OP_SUB:  s.wbData = rn - rm;
            `OP_AND:  s.wbData = rn & rm;
            `OP_ORR:  s.wbData = rn | rm;
            `OP_EOR:  s.wbData = rn ^ rm;
            `OP_LDUR: s.wbData = refMem[addr[4:2]];
            default:  s.wbData = '0;
        endcase
        s.wbEn = ins[31:21] inside {`OP_ADD, `OP_SUB, `OP_AND, `OP_ORR, `OP_EOR, `OP_LDUR};
        if (ins[31:22] == `OP_ADDI || ins[31:22] == `OP_SUBI) begin
            s.wbEn   = 1'b1;
            s.wbData = (ins[31:22] == `OP_ADDI) ? rn + {20'd0, ins[21:10]}
                                                : rn - {20'd0, ins[21:10]};
        end
        if (ins[31:21] == `OP_LDUR) begin
            s.memRd   = 1'b1;
            s.memAddr = addr;
        end
        if (ins[31:21] == `OP_STUR) begin
            s.memWr   = 1'b1;
            s.memAddr = addr;
            s.memData = rt;
        end
        if (ins[31:24] == `OP_CBZ && rt == '0) begin
            s.nextPc = pc + {{11{ins[23]}}, ins[23:5], 2'b00};
        end
        if (ins[31:26] == `OP_B) begin
            s.nextPc = pc + {{4{ins[25]}}, ins[25:0], 2'b00};
        end
        return s;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic buildImages();
        logic [31:0] r;
        logic [31:0] immR;
        int          rd;
        int          rn;
        int          rm;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'hFFFF_0000 | i;    // undecodable filler
        end
        for (int i = 0; i < 150; i++) begin
            rngState = xorshift32(rngState);
            r        = rngState;
            rngState = xorshift32(rngState);
            immR     = rngState;
            rd       = pickReg(r[7:0]);
            rn       = pickReg(r[15:8]);
            rm       = pickReg(r[23:16]);
            case (r[31:24] % 7)
                0:       imem[i] = encR(`OP_ADD, rm, rn, rd);
                1:       imem[i] = encR(`OP_SUB, rm, rn, rd);
                2:       imem[i] = encR(`OP_AND, rm, rn, rd);
                3:       imem[i] = encR(`OP_ORR, rm, rn, rd);
                4:       imem[i] = encR(`OP_EOR, rm, rn, rd);
                5:       imem[i] = encI(`OP_ADDI, immR, rn, rd);
                default: imem[i] = encI(`OP_SUBI, immR, rn, rd);
            endcase
        end
        imem[150] = 32'hDEAD_BEEF;               // unknown opcode
        imem[151] = encI(`OP_ADDI, 'h100, 31, 10);
        imem[152] = encI(`OP_ADDI, 3, 31, 11);  // three passes
        imem[153] = encD(`OP_LDUR, 0, 10, 12);
        imem[154] = encD(`OP_LDUR, 8, 10, 13);
        imem[155] = encR(`OP_ADD, 13, 12, 14);
        imem[156] = encD(`OP_STUR, 4, 10, 14);
        imem[157] = encD(`OP_STUR, -4, 10, 13);
        imem[158] = encI(`OP_ADDI, 8, 10, 10);
        imem[159] = encI(`OP_SUBI, 1, 11, 11);
        imem[160] = encCbz(2, 11);               // leave loop once x11 hits zero
        imem[161] = encB(-8);
        imem[162] = encCbz(2, 31);               // xzr, always taken
        imem[163] = 32'hDEAD_BEEF;
        imem[164] = encB(0);                     // spin here till the end
        for (int i = 0; i < 8; i++) begin
            rngState  = xorshift32(rngState);
            dmem[i]   = rngState;
            refMem[i] = rngState;
        end
    endtask

    initial begin
        stepT want;
        clk        = 1'b0;
        rstN       = 1'b0;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        rngState   = 32'd3;
        buildImages();
        for (int i = 0; i < `REG_COUNT; i++) begin
            refRegs[i] = i;
        end
        refPc = `START_PC;
        inst  = fetchWord(`START_PC);
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstN = 1'b1;
        repeat (NUM_STEPS) begin
            @(negedge clk);    // mid cycle, everything settled
            want = modelStep(refPc, fetchWord(refPc));
            checkValue(instAddr, refPc, "instAddr");
            checkValue(regWb.en, want.wbEn, "regWb.en");
            if (want.wbEn) begin
                checkValue(regWb.idx, want.wbIdx, "regWb.idx");
                checkValue(regWb.data, want.wbData, "regWb.data");
            end
            checkValue(memReq.read, want.memRd, "memReq.read");
            checkValue(memReq.write, want.memWr, "memReq.write");
            if (want.memRd || want.memWr) begin
                checkValue(memReq.addr, want.memAddr, "memReq.addr");
            end
            if (want.memWr) begin
                checkValue(memReq.storeData, want.memData, "memReq.storeData");
            end
            if (want.wbEn && want.wbIdx != `ZERO_REG) begin
                refRegs[want.wbIdx] = want.wbData;
            end
            if (want.memWr) begin
                refMem[want.memAddr[4:2]] = want.memData;
            end
            refPc = want.nextPc;
        end
        errorCount += dut.uAsserts.assertFails;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+source
source/cpuPkg.sv
source/programCounter.sv
source/instructionDecoder.sv
source/registerFile.sv
source/executeUnit.sv
source/cpuTop.sv
tests/cpu_assertions.sv
tests/cpuTb.sv
